// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat vlog.f)) include/riscv_macros.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_decode_top: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_decode_top -Mdir obj_dir -f vlog.f

run: obj_dir/Vtb_decode_top
	./obj_dir/Vtb_decode_top | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define XLEN      32
`define ALU_OP_W  5

// instruction field widths
`define OPC_W     7
`define REG_W     5
`define FUNC3_W   3
`define FUNC7_W   7
`define IMM12_W   12

`define MRET_IMM  12'h302
`define FUNC7_ALT 7'h20

// opcode[1:0] of every 32-bit encoding
`define OPC_QUAD     2'b11

// opcode[6:2] encodings
`define OPC_LOAD     5'b00000
`define OPC_MISC_MEM 5'b00011
`define OPC_OP_IMM   5'b00100
`define OPC_AUIPC    5'b00101
`define OPC_STORE    5'b01000
`define OPC_OP       5'b01100
`define OPC_LUI      5'b01101
`define OPC_BRANCH   5'b11000
`define OPC_JALR     5'b11001
`define OPC_JAL      5'b11011
`define OPC_SYSTEM   5'b11100

`endif

// ==== source/ctrl_gen.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module ctrl_gen
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  class_word_t cw_i,
  output logic        valid_o,
  input  logic        ready_i,
  output ctrl_t       ctrl_o
);

  r_fields_t rf;
  i_fields_t ifl;
  logic      alt;
  logic      imm_ok;
  logic      reg_ok;
  alu_op_e   base_op;
  alu_op_e   imm_op;
  alu_op_e   reg_op;
  ctrl_t     d;

  assign rf  = cw_i.word.r;
  assign ifl = cw_i.word.i;
  assign alt = (rf.func7 == `FUNC7_ALT);

  always_comb begin
    case (rf.func3)
      3'd0:    base_op = ALU_ADD;
      3'd1:    base_op = ALU_SLL;
      3'd2:    base_op = ALU_SLTS;
      3'd3:    base_op = ALU_SLTU;
      3'd4:    base_op = ALU_XOR;
      3'd5:    base_op = ALU_SRL;
      3'd6:    base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  end

  // alt func7 turns srl into sra, and add into sub for OP only
  assign imm_op = (rf.func3 == 3'd5 && alt) ? ALU_SRA : base_op;
  assign reg_op = !alt ? base_op : (rf.func3 == 3'd0) ? ALU_SUB : ALU_SRA;
  assign imm_ok = (rf.func3 == 3'd1) ? (rf.func7 == '0) :
                  (rf.func3 == 3'd5) ? (rf.func7 == '0 || alt) : 1'b1;
  assign reg_ok = (rf.func7 == '0) || (alt && (rf.func3 == 3'd0 || rf.func3 == 3'd5));

  always_comb begin
    d = '0;
    case (cw_i.cls)
      CLS_LOAD:
        if (rf.func3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
          d.a_sel    = A_RS1;
          d.b_sel    = B_IMM_I;
          d.wb_sel   = WB_MEM;
          d.gpr_we   = 1'b1;
          d.mem_req  = 1'b1;
          d.mem_size = mem_size_e'(rf.func3);
        end else d.illegal = 1'b1;
      CLS_STORE:
        if (rf.func3 inside {3'd0, 3'd1, 3'd2}) begin
          d.b_sel    = B_IMM_S;
          d.mem_req  = 1'b1;
          d.mem_we   = 1'b1;
          d.mem_size = mem_size_e'(rf.func3);
        end else d.illegal = 1'b1;
      CLS_OP_IMM:
        if (imm_ok) begin
          d.a_sel  = A_RS1;
          d.b_sel  = B_IMM_I;
          d.alu_op = imm_op;
          d.gpr_we = 1'b1;
        end else d.illegal = 1'b1;
      CLS_OP:
        if (reg_ok) begin
          d.a_sel  = A_RS1;
          d.b_sel  = B_RS2;
          d.alu_op = reg_op;
          d.gpr_we = 1'b1;
        end else d.illegal = 1'b1;
      CLS_AUIPC: begin
        d.a_sel  = A_PC;
        d.b_sel  = B_IMM_U;
        d.gpr_we = 1'b1;
      end
      CLS_LUI: begin
        d.a_sel  = A_ZERO;
        d.b_sel  = B_IMM_U;
        d.gpr_we = 1'b1;
      end
      CLS_BRANCH:
        if (rf.func3[2:1] == 2'b01) d.illegal = 1'b1;   // func3 2 and 3 unused
        else begin
          d.a_sel  = A_RS1;
          d.b_sel  = B_RS2;
          d.branch = 1'b1;
          case (rf.func3)
            3'd0:    d.alu_op = ALU_EQ;
            3'd1:    d.alu_op = ALU_NE;
            3'd4:    d.alu_op = ALU_LTS;
            3'd5:    d.alu_op = ALU_GES;
            3'd6:    d.alu_op = ALU_LTU;
            default: d.alu_op = ALU_GEU;
          endcase
        end
      CLS_JAL: begin
        d.a_sel  = A_PC;
        d.b_sel  = B_INC4;
        d.jal    = 1'b1;
        d.gpr_we = 1'b1;
      end
      CLS_JALR:
        if (rf.func3 == 3'd0) begin
          d.a_sel  = A_PC;
          d.b_sel  = B_INC4;
          d.jalr   = 1'b1;
          d.gpr_we = 1'b1;
        end else d.illegal = 1'b1;
      CLS_MISC_MEM: d.illegal = (rf.func3 != 3'd0);   // fence is a no-op
      CLS_SYSTEM:
        if (rf.func3 == 3'd0 && ifl.imm12 == `MRET_IMM) d.mret = 1'b1;
        else d.illegal = 1'b1;   // csr, ecall, ebreak unsupported
      default: d.illegal = 1'b1;
    endcase
  end

  assign ready_o = !valid_o || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      ctrl_o <= d;
    end
  end

  a_illegal_quiet: assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_o && ctrl_o.illegal |->
      !(ctrl_o.gpr_we || ctrl_o.mem_req || ctrl_o.branch ||
        ctrl_o.jal || ctrl_o.jalr || ctrl_o.mret)
  );

endmodule

// ==== source/decode_top.sv ====
`timescale 1ns/1ns

module decode_top
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   instr_req_i,
  input  instr_u instr_i,
  output logic   instr_ack_o,
  output logic   dec_req_o,
  output ctrl_t  dec_o,
  input  logic   dec_ack_i
);

  logic        s1_valid;
  logic        s1_ready;
  instr_u      s1_word;
  logic        s2_valid;
  logic        s2_ready;
  class_word_t s2_cw;
  logic        s3_valid;
  logic        s3_ready;
  ctrl_t       s3_ctrl;

  instr_accept u_accept (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .valid_o     (s1_valid),
    .word_o      (s1_word),
    .ready_i     (s1_ready)
  );

  opcode_classify u_classify (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (s1_valid),
    .ready_o (s1_ready),
    .word_i  (s1_word),
    .valid_o (s2_valid),
    .ready_i (s2_ready),
    .cw_o    (s2_cw)
  );

  ctrl_gen u_ctrl (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (s2_valid),
    .ready_o (s2_ready),
    .cw_i    (s2_cw),
    .valid_o (s3_valid),
    .ready_i (s3_ready),
    .ctrl_o  (s3_ctrl)
  );

  result_issue u_issue (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (s3_valid),
    .ready_o   (s3_ready),
    .ctrl_i    (s3_ctrl),
    .dec_req_o (dec_req_o),
    .dec_o     (dec_o),
    .dec_ack_i (dec_ack_i)
  );

endmodule

// ==== source/instr_accept.sv ====
`timescale 1ns/1ns

module instr_accept
  import riscv_isa_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   instr_req_i,
  input  instr_u instr_i,
  output logic   instr_ack_o,
  output logic   valid_o,
  output instr_u word_o,
  input  logic   ready_i
);

  logic take;

  // new req, not yet acked, and the slot is free or draining
  assign take = instr_req_i && !instr_ack_o && (!valid_o || ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      instr_ack_o <= 1'b0;
      valid_o     <= 1'b0;
    end else begin
      if (take) begin
        instr_ack_o <= 1'b1;
      end else if (!instr_req_i) begin
        instr_ack_o <= 1'b0;   // producer dropped req
      end
      if (take) begin
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      word_o <= instr_i;
    end
  end

  // ack only ever answers a req that was already up
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(instr_ack_o) |-> $past(instr_req_i)
  );

endmodule

// ==== source/opcode_classify.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module opcode_classify
  import riscv_isa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  instr_u      word_i,
  output logic        valid_o,
  input  logic        ready_i,
  output class_word_t cw_o
);

  opcode_class_e cls;

  always_comb begin
    cls = CLS_BAD;
    if (word_i.r.opcode[1:0] == `OPC_QUAD) begin
      case (word_i.r.opcode[6:2])
        `OPC_LOAD:     cls = CLS_LOAD;
        `OPC_MISC_MEM: cls = CLS_MISC_MEM;
        `OPC_OP_IMM:   cls = CLS_OP_IMM;
        `OPC_AUIPC:    cls = CLS_AUIPC;
        `OPC_STORE:    cls = CLS_STORE;
        `OPC_OP:       cls = CLS_OP;
        `OPC_LUI:      cls = CLS_LUI;
        `OPC_BRANCH:   cls = CLS_BRANCH;
        `OPC_JALR:     cls = CLS_JALR;
        `OPC_JAL:      cls = CLS_JAL;
        `OPC_SYSTEM:   cls = CLS_SYSTEM;
        default:       cls = CLS_BAD;
      endcase
    end
  end

  assign ready_o = !valid_o || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      cw_o.word <= word_i;
      cw_o.cls  <= cls;
    end
  end

endmodule

// ==== source/result_issue.sv ====
`timescale 1ns/1ns

module result_issue
  import riscv_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  ctrl_t ctrl_i,
  output logic  dec_req_o,
  output ctrl_t dec_o,
  input  logic  dec_ack_i
);

  // idle only once the previous four-phase cycle has closed
  assign ready_o = !dec_req_o && !dec_ack_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_req_o <= 1'b0;
    end else if (valid_i && ready_o) begin
      dec_req_o <= 1'b1;
    end else if (dec_req_o && dec_ack_i) begin
      dec_req_o <= 1'b0;   // consumer took it
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      dec_o <= ctrl_i;
    end
  end

  a_payload_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    dec_req_o && !dec_ack_i |=> $stable(dec_o)
  );

endmodule

// ==== source/riscv_ctrl_pkg.sv ====
`include "riscv_macros.svh"

package riscv_ctrl_pkg;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } a_sel_e;

  typedef enum logic [2:0] {
    B_RS2   = 3'd0,
    B_IMM_I = 3'd1,
    B_IMM_U = 3'd2,
    B_IMM_S = 3'd3,
    B_INC4  = 3'd4
  } b_sel_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1
  } wb_sel_e;

  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLTS = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_EQ   = 5'b11000,   // compare ops have msb set
    ALU_NE   = 5'b11001,
    ALU_LTS  = 5'b11100,
    ALU_GES  = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [2:0] {
    LDST_B  = 3'd0,
    LDST_H  = 3'd1,
    LDST_W  = 3'd2,
    LDST_BU = 3'd4,
    LDST_HU = 3'd5
  } mem_size_e;

  typedef struct packed {
    a_sel_e    a_sel;
    b_sel_e    b_sel;
    wb_sel_e   wb_sel;
    alu_op_e   alu_op;
    mem_size_e mem_size;
    logic      mem_req;
    logic      mem_we;
    logic      gpr_we;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      mret;
    logic      illegal;
  } ctrl_t;

endpackage

// ==== source/riscv_isa_pkg.sv ====
`include "riscv_macros.svh"

package riscv_isa_pkg;

  typedef enum logic [3:0] {
    CLS_LOAD,
    CLS_MISC_MEM,
    CLS_OP_IMM,
    CLS_AUIPC,
    CLS_STORE,
    CLS_OP,
    CLS_LUI,
    CLS_BRANCH,
    CLS_JALR,
    CLS_JAL,
    CLS_SYSTEM,
    CLS_BAD       // bad quadrant or unknown opcode
  } opcode_class_e;

  typedef struct packed {
    logic [`FUNC7_W-1:0] func7;
    logic [`REG_W-1:0]   rs2;
    logic [`REG_W-1:0]   rs1;
    logic [`FUNC3_W-1:0] func3;
    logic [`REG_W-1:0]   rd;
    logic [`OPC_W-1:0]   opcode;
  } r_fields_t;

  typedef struct packed {
    logic [`IMM12_W-1:0] imm12;
    logic [`REG_W-1:0]   rs1;
    logic [`FUNC3_W-1:0] func3;
    logic [`REG_W-1:0]   rd;
    logic [`OPC_W-1:0]   opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;   // func7 view for shifts and OP
    i_fields_t i;   // imm12 view for mret
  } instr_u;

  typedef struct packed {
    instr_u        word;
    opcode_class_e cls;
  } class_word_t;

endpackage

// ==== test/tb_decode_model.sv ====
`include "riscv_macros.svh"

package tb_decode_model;

  import riscv_ctrl_pkg::*;

  function automatic logic [31:0] build_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] build_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // register/immediate arithmetic by func3
  function automatic alu_op_e arith_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLTS;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_EQ;
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LTS;
      3'd5:    return ALU_GES;
      3'd6:    return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  function automatic ctrl_t alu_ctrl(input a_sel_e a, input b_sel_e b, input alu_op_e op);
    ctrl_t c;
    c = '0;
    c.a_sel  = a;
    c.b_sel  = b;
    c.alu_op = op;
    c.gpr_we = 1'b1;
    return c;
  endfunction

  // expected bundle straight from the RV32I encoding rules
  function automatic ctrl_t ref_decode(input logic [31:0] w);
    ctrl_t      c;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       alt;
    f7  = w[31:25];
    f3  = w[14:12];
    alt = (f7 == `FUNC7_ALT);
    c = '0;
    c.illegal = 1'b1;
    case (w[6:0])
      7'h03: if (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7) begin
        c = alu_ctrl(A_RS1, B_IMM_I, ALU_ADD);
        c.wb_sel   = WB_MEM;
        c.mem_req  = 1'b1;
        c.mem_size = mem_size_e'(f3);
      end
      7'h23: if (f3 <= 3'd2) begin
        c = '0;
        c.b_sel    = B_IMM_S;
        c.mem_req  = 1'b1;
        c.mem_we   = 1'b1;
        c.mem_size = mem_size_e'(f3);
      end
      7'h13: begin
        if (f3 == 3'd1 && f7 == 7'd0) c = alu_ctrl(A_RS1, B_IMM_I, ALU_SLL);
        else if (f3 == 3'd5 && f7 == 7'd0) c = alu_ctrl(A_RS1, B_IMM_I, ALU_SRL);
        else if (f3 == 3'd5 && alt) c = alu_ctrl(A_RS1, B_IMM_I, ALU_SRA);
        else if (f3 != 3'd1 && f3 != 3'd5) c = alu_ctrl(A_RS1, B_IMM_I, arith_op(f3));
      end
      7'h33: begin
        if (f7 == 7'd0) c = alu_ctrl(A_RS1, B_RS2, arith_op(f3));
        else if (alt && f3 == 3'd0) c = alu_ctrl(A_RS1, B_RS2, ALU_SUB);
        else if (alt && f3 == 3'd5) c = alu_ctrl(A_RS1, B_RS2, ALU_SRA);
      end
      7'h17: c = alu_ctrl(A_PC, B_IMM_U, ALU_ADD);
      7'h37: c = alu_ctrl(A_ZERO, B_IMM_U, ALU_ADD);
      7'h63: if (f3 != 3'd2 && f3 != 3'd3) begin
        c = '0;
        c.a_sel  = A_RS1;
        c.b_sel  = B_RS2;
        c.alu_op = branch_op(f3);
        c.branch = 1'b1;
      end
      7'h6f: begin
        c = alu_ctrl(A_PC, B_INC4, ALU_ADD);
        c.jal = 1'b1;
      end
      7'h67: if (f3 == 3'd0) begin
        c = alu_ctrl(A_PC, B_INC4, ALU_ADD);
        c.jalr = 1'b1;
      end
      7'h0f: if (f3 == 3'd0) c = '0;
      7'h73: if (f3 == 3'd0 && w[31:20] == `MRET_IMM) begin
        c = '0;
        c.mret = 1'b1;
      end
      default: ;
    endcase
    return c;
  endfunction

endpackage

// ==== test/tb_decode_top.sv ====
`timescale 1ns/1ns
`include "riscv_macros.svh"

module tb_decode_top
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
  import tb_decode_model::*;
();

  localparam int N_RAND = 200;

  logic   clk_i;
  logic   rst_i;
  logic   instr_req_i;
  instr_u instr_i;
  logic   instr_ack_o;
  logic   dec_req_o;
  ctrl_t  dec_o;
  logic   dec_ack_i;

  ctrl_t       exp_q[$];
  string       name_q[$];
  logic [31:0] dir_q[$];
  // 11 legal opcodes, then two unknown and two with bad low bits
  logic [6:0]  opcodes [15] = '{7'h03, 7'h0f, 7'h13, 7'h17, 7'h23, 7'h33, 7'h37, 7'h63,
                                7'h67, 7'h6f, 7'h73, 7'h0b, 7'h57, 7'h02, 7'h31};
  int          value_errs = 0;
  int          proto_errs = 0;
  int          sent = 0;
  int          received = 0;
  int          cycles = 0;
  int          limit = 100;
  string       test_name = "reset";

  decode_top UUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .dec_req_o   (dec_req_o),
    .dec_o       (dec_o),
    .dec_ack_i   (dec_ack_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, %0d bundles still outstanding", cycles, exp_q.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // one full four-phase cycle on the input side
  task automatic send_word(input logic [31:0] w);
    exp_q.push_back(ref_decode(w));
    name_q.push_back(test_name);
    sent++;
    instr_i     = w;
    instr_req_i = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!instr_ack_o);
    repeat ($urandom_range(0, 3)) begin   // req lingers after ack
      @(posedge clk_i);
      #1;
    end
    instr_req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (instr_ack_o);
  endtask

  a_in_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(instr_ack_o) |-> $past(instr_req_i))
  else begin
    proto_errs++;
    $display("instr_ack_o rose while instr_req_i was low");
  end

  a_in_release: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(instr_ack_o) |-> !$past(instr_req_i))
  else begin
    proto_errs++;
    $display("instr_ack_o fell while instr_req_i was still high");
  end

  a_out_start: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(dec_req_o) |-> !$past(dec_ack_i))
  else begin
    proto_errs++;
    $display("dec_req_o rose before dec_ack_i had dropped");
  end

  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_req_o && !dec_ack_i |=> $stable(dec_o))
  else begin
    proto_errs++;
    $display("dec_o changed while waiting for dec_ack_i");
  end

  a_out_release: assert property (@(posedge clk_i) disable iff (rst_i)
    dec_req_o && dec_ack_i |=> !dec_req_o)
  else begin
    proto_errs++;
    $display("dec_req_o stayed high one cycle after dec_ack_i");
  end

  // consumer with a random ack delay
  initial begin
    ctrl_t want;
    string name;
    dec_ack_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!rst_i && dec_req_o && !dec_ack_i) begin
        received++;
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("bundle %h arrived with no instruction outstanding", dec_o);
        end else begin
          want = exp_q.pop_front();
          name = name_q.pop_front();
          a_bundle: assert (dec_o === want) else begin
            value_errs++;
            $display("FAIL %s: expected %h, actual %h", name, want, dec_o);
          end
        end
        repeat ($urandom_range(0, 6)) begin
          @(posedge clk_i);
          #1;
        end
        dec_ack_i = 1'b1;
        do begin
          @(posedge clk_i);
          #1;
        end while (dec_req_o);
        repeat ($urandom_range(0, 3)) begin   // ack lingers after req drops
          @(posedge clk_i);
          #1;
        end
        dec_ack_i = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] w;
    instr_req_i = 1'b0;
    instr_i     = '0;
    rst_i       = 1'b1;
    void'($urandom(32'h03dee892));
    for (int op = 0; op < 15; op++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        dir_q.push_back(build_r(7'h00, 5'd3, 5'd2, 3'(f3), 5'd1, opcodes[op]));
        dir_q.push_back(build_r(`FUNC7_ALT, 5'd3, 5'd2, 3'(f3), 5'd1, opcodes[op]));
        dir_q.push_back(build_r(7'h01, 5'd3, 5'd2, 3'(f3), 5'd1, opcodes[op]));
      end
    end
    limit = 40 * (dir_q.size() + 5 + N_RAND) + 100;
    repeat (3) @(posedge clk_i);
    #1;
    a_reset: assert (instr_ack_o === 1'b0 && dec_req_o === 1'b0) else begin
      value_errs++;
      $display("FAIL reset: expected ack 0 req 0, actual ack %b req %b",
               instr_ack_o, dec_req_o);
    end
    rst_i = 1'b0;
    test_name = "classes";
    foreach (dir_q[k]) send_word(dir_q[k]);
    test_name = "system";
    send_word(build_i(`MRET_IMM, 5'd0, 3'd0, 5'd0, 7'h73));
    send_word(build_i(12'h303, 5'd0, 3'd0, 5'd0, 7'h73));   // one off from mret
    send_word(build_i(12'h000, 5'd0, 3'd0, 5'd0, 7'h73));   // ecall
    send_word(build_i(12'h001, 5'd0, 3'd0, 5'd0, 7'h73));   // ebreak
    send_word(build_i(12'h300, 5'd4, 3'd2, 5'd6, 7'h73));   // csrrs
    test_name = "random";
    for (int k = 0; k < N_RAND; k++) begin
      w = $urandom;
      if ($urandom_range(0, 3) != 0) w[6:0] = opcodes[$urandom_range(0, 10)];
      send_word(w);
    end
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (20) @(posedge clk_i);   // room for a stray extra bundle
    if (received != sent) begin
      proto_errs++;
      $display("sent %0d instructions but received %0d bundles", sent, received);
    end
    $display("errors: %0d value, %0d protocol over %0d instructions",
             value_errs, proto_errs, sent);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
source/riscv_isa_pkg.sv
source/riscv_ctrl_pkg.sv
source/instr_accept.sv
source/opcode_classify.sv
source/ctrl_gen.sv
source/result_issue.sv
source/decode_top.sv
test/tb_decode_model.sv
test/tb_decode_top.sv
